//--- list.f
source/mcu_pkg.sv
source/mcu_reg_if.sv
source/mcu_addr_decode.sv
source/mcu_reg_file.sv
source/mcu_bus_ack.sv
source/mcu_top.sv
dv/mcu_assert.sv
dv/mcu_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --timing --assert
TOP      = mcu_tb
FILELIST = list.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = Simulation passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(TOOL) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/mcu_tb.sv
`timescale 1ns/1ps

module mcu_tb;

    localparam int CLK_PERIOD  = 40;
    localparam int NREGS       = 11;
    // Reset, about 60 register and ROM cycles of up to 10 clocks, BERR hold
    localparam int TEST_CYCLES = 3 + 60 * 10 + 260;

    logic        clk32;
    logic        isndcsb;
    logic [2:0]  fc_i;
    logic        as_n_i, rw_i, uds_n_i, lds_n_i;
    logic [23:1] a_i;
    logic [15:0] din_i;
    logic [15:0] dout_o;
    logic        dtack_n_o, berr_n_o, mfpcs_n_o;
    logic [7:0]  rom_n_o;

    logic [15:0] lfsr;
    int          errors;
    int          cycles;
    logic [15:0] rdata;
    logic [7:0]  rom_seen;
    logic        mfp_seen;
    logic        berr_seen;
    logic [23:0] reg_adr  [NREGS];
    logic [15:0] reg_mask [NREGS];   // Upper lane flags sit in bits 9:8
    logic [15:0] wr_val   [NREGS];

    mcu_top u_dut (.*);

    initial begin
        clk32 = 1'b0;
        forever #(CLK_PERIOD / 2) clk32 = ~clk32;
    end

    initial begin
        #(TEST_CYCLES * CLK_PERIOD + 100 * CLK_PERIOD);
        $display("Watchdog expired, a bus cycle never ended");
        fail_stop();
    end

    task automatic fail_stop();
        errors++;
        $display("Simulation failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_val(input string name, input logic [15:0] exp, input logic [15:0] act);
        assert (exp === act) else begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            fail_stop();
        end
    endtask

    // Galois LFSR, taps 16 14 13 11, one step per bit
    function automatic logic [15:0] lfsr_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            v    = {v[14:0], lfsr[0]};
        end
        return v;
    endfunction

    // Lower lane regs float the upper byte, flag regs float the lower byte
    function automatic logic [15:0] expect_rd(input logic [15:0] mask, input logic [15:0] val);
        return ((mask[15:8] != 8'h00) ? 16'hFCFF : 16'hFF00) | (val & mask);
    endfunction

    // Called on a falling edge, AS held until DTACK, BERR or the limit
    task automatic bus_cycle(input logic [23:0] adr, input logic rw, input logic [15:0] wdata,
                             input int limit);
        fc_i    = 3'b101;   // Supervisor data
        a_i     = adr[23:1];
        rw_i    = rw;
        din_i   = wdata;
        uds_n_i = 1'b0;
        lds_n_i = 1'b0;
        as_n_i  = 1'b0;
        cycles  = 0;
        do begin
            @(posedge clk32);
            cycles++;
            if (cycles == 1) begin
                rom_seen = rom_n_o;
                mfp_seen = mfpcs_n_o;
            end
        end while (dtack_n_o && berr_n_o && cycles < limit);
        rdata     = dout_o;
        berr_seen = ~berr_n_o;
        @(negedge clk32);
        as_n_i  = 1'b1;
        uds_n_i = 1'b1;
        lds_n_i = 1'b1;
        @(negedge clk32);   // Bus idle for one cycle
    endtask

    task automatic bus_write(input logic [23:0] adr, input logic [15:0] data);
        bus_cycle(adr, 1'b0, data, 20);
    endtask

    task automatic bus_read(input logic [23:0] adr);
        bus_cycle(adr, 1'b1, 16'h0000, 20);
    endtask

    task automatic rom_probe(input logic [23:0] adr, input logic rw, input logic [7:0] sel);
        bus_cycle(adr | 24'(lfsr_bits(2) << 1), rw, 16'h0000, 2);
        check_val("test_rom_map", {8'h00, ~sel}, {8'h00, rom_seen});
    endtask

    task automatic test_reset();
        check_val("test_reset outputs", 16'h07FF,
                  {5'b0, dtack_n_o, berr_n_o, mfpcs_n_o, rom_n_o});
        for (int i = 0; i < NREGS; i++) begin
            bus_read(reg_adr[i]);
            check_val("test_reset", expect_rd(reg_mask[i], 16'h0000), rdata);
        end
    endtask

    task automatic test_regs();
        for (int i = 0; i < NREGS; i++) begin
            wr_val[i] = lfsr_bits(16);
            bus_write(reg_adr[i], wr_val[i]);
        end
        for (int i = 0; i < NREGS; i++) begin
            bus_read(reg_adr[i]);
            check_val("test_regs", expect_rd(reg_mask[i], wr_val[i]), rdata);
        end
    endtask

    task automatic test_rom_map();
        bus_write(24'hFF9000, 16'h0000);   // No cartridge
        rom_probe(24'hE80000, 1'b1, 8'h01);
        rom_probe(24'hE40000, 1'b1, 8'h02);
        rom_probe(24'hE00000, 1'b1, 8'h04);
        rom_probe(24'hDC0000, 1'b1, 8'h00);
        rom_probe(24'hD80000, 1'b1, 8'h00);
        rom_probe(24'hD40000, 1'b1, 8'h20);
        rom_probe(24'hD00000, 1'b1, 8'h40);
        rom_probe(24'hFE0000, 1'b1, 8'h80);
        rom_probe(24'h000000, 1'b1, 8'h04);   // Reset vector
        rom_probe(24'hFB0000, 1'b1, 8'h08);
        rom_probe(24'hFA0000, 1'b1, 8'h10);
        bus_write(24'hFF9000, 16'h0100);
        rom_probe(24'hDC0000, 1'b1, 8'h08);
        rom_probe(24'hD80000, 1'b1, 8'h10);
        rom_probe(24'hFB0000, 1'b1, 8'h00);
        rom_probe(24'hFA0000, 1'b1, 8'h00);
        rom_probe(24'hE00000, 1'b0, 8'h00);
    endtask

    task automatic test_mfp_ack();
        bus_cycle(24'hFFFA00 | 24'(lfsr_bits(5) << 1), 1'b1, 16'h0000, 2);
        check_val("test_mfp_ack mfpcs", 16'h0000, {15'h0, mfp_seen});
        bus_read(24'hFF8202);
        check_val("test_mfp_ack reg cycles", 16'd1, 16'(cycles));
        bus_read(24'hFF8900);
        assert (cycles > 4 && cycles <= 9) else begin
            $display("Sound register DTACK came after %0d cycles, not 5 to 9", cycles);
            fail_stop();
        end
    endtask

    task automatic test_berr();
        bus_cycle(24'h400000, 1'b1, 16'h0000, 300);
        assert (berr_seen && cycles > 252 && cycles <= 257) else begin
            $display("Bus error missing or mistimed after %0d cycles", cycles);
            fail_stop();
        end
        check_val("test_berr release", 16'h0003, {14'h0, berr_n_o, dtack_n_o});
    endtask

    initial begin
        lfsr     = 16'd23297;
        errors   = 0;
        isndcsb  = 1'b1;
        fc_i     = 3'b000;
        as_n_i   = 1'b1;
        rw_i     = 1'b1;
        uds_n_i  = 1'b1;
        lds_n_i  = 1'b1;
        a_i      = '0;
        din_i    = '0;
        reg_adr  = '{24'hFF8200, 24'hFF8202, 24'hFF820C, 24'hFF820E, 24'hFF8000, 24'hFF8900,
                     24'hFF8902, 24'hFF8904, 24'hFF8906, 24'hFF9000, 24'hFF820A};
        reg_mask = '{16'h003F, 16'h00FF, 16'h00FE, 16'h00FF, 16'h000F, 16'h000F,
                     16'h003F, 16'h00FF, 16'h00FE, 16'h0100, 16'h0200};
        repeat (3) @(posedge clk32);
        @(negedge clk32);
        isndcsb = 1'b0;
        test_reset();
        test_regs();
        test_rom_map();
        test_mfp_ack();
        test_berr();
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- dv/mcu_assert.sv
`timescale 1ns/1ps

module mcu_assert (
    input logic clk32,
    input logic isndcsb,
    input logic as_n_i,
    input logic snd_access_i,
    input logic ack_i,
    input logic dtack_n_i,
    input logic berr_n_i
);

    // No stale sound acknowledge survives a cycle with AS released
    assert property (@(posedge clk32) disable iff (isndcsb)
        ($past(as_n_i) && !ack_i) |-> dtack_n_i)
        else $error("DTACK low at the start of a new access");

    assert property (@(posedge clk32) disable iff (isndcsb)
        (as_n_i && $past(as_n_i)) |-> berr_n_i)
        else $error("BERR low with AS released");

    // Sound page waits for two 8 MHz ticks
    assert property (@(posedge clk32) disable iff (isndcsb)
        $rose(snd_access_i) |-> dtack_n_i ##1 dtack_n_i ##1 dtack_n_i ##1 dtack_n_i)
        else $error("Sound access acknowledged too early");

endmodule

bind mcu_bus_ack mcu_assert u_assert (
    .clk32        (clk32),
    .isndcsb      (isndcsb),
    .as_n_i       (as_n_i),
    .snd_access_i (reg_i.snd_access),
    .ack_i        (reg_i.ack),
    .dtack_n_i    (dtack_n_o),
    .berr_n_i     (berr_n_o)
);

//--- source/mcu_top.sv
`timescale 1ns/1ps

module mcu_top (
    input  logic                            clk32,
    input  logic                            isndcsb,
    input  logic [2:0]                      fc_i,
    input  logic                            as_n_i,
    input  logic                            rw_i,
    input  logic                            uds_n_i,
    input  logic                            lds_n_i,
    input  logic [mcu_pkg::ADDR_W:1]        a_i,
    input  logic [mcu_pkg::DATA_W-1:0]      din_i,
    output logic [mcu_pkg::DATA_W-1:0]      dout_o,
    output logic                            dtack_n_o,
    output logic                            berr_n_o,
    output logic [mcu_pkg::ROM_BANKS-1:0]   rom_n_o,
    output logic                            mfpcs_n_o
);

    logic                       gamecart;
    logic [mcu_pkg::BYTE_W-1:0] rd_low;
    logic [1:0]                 rd_high;

    mcu_reg_if reg_bus ();

    mcu_addr_decode u_decode (
        .clk32      (clk32),
        .isndcsb    (isndcsb),
        .fc_i       (fc_i),
        .as_n_i     (as_n_i),
        .rw_i       (rw_i),
        .uds_n_i    (uds_n_i),
        .lds_n_i    (lds_n_i),
        .a_i        (a_i),
        .din_i      (din_i),
        .gamecart_i (gamecart),
        .rom_n_o    (rom_n_o),
        .mfpcs_n_o  (mfpcs_n_o),
        .reg_o      (reg_bus.decoder)
    );

    mcu_reg_file u_regs (
        .clk32      (clk32),
        .isndcsb    (isndcsb),
        .reg_i      (reg_bus.sink),
        .gamecart_o (gamecart),
        .rd_low_o   (rd_low),
        .rd_high_o  (rd_high)
    );

    // 32 MHz / 4, two ticks for sound, 64 ticks to bus error
    mcu_bus_ack #(
        .ENA_DIV       (4),
        .SND_ACK_TICKS (2),
        .BERR_TICKS    (64)
    ) u_ack (
        .clk32     (clk32),
        .isndcsb   (isndcsb),
        .as_n_i    (as_n_i),
        .reg_i     (reg_bus.sink),
        .rd_low_i  (rd_low),
        .rd_high_i (rd_high),
        .dout_o    (dout_o),
        .dtack_n_o (dtack_n_o),
        .berr_n_o  (berr_n_o)
    );

endmodule

//--- source/mcu_bus_ack.sv
`timescale 1ns/1ps

module mcu_bus_ack #(
    parameter int ENA_DIV       = 4,
    parameter int SND_ACK_TICKS = 2,
    parameter int BERR_TICKS    = 64
) (
    input  logic                        clk32,
    input  logic                        isndcsb,
    input  logic                        as_n_i,
    mcu_reg_if.sink                     reg_i,
    input  logic [mcu_pkg::BYTE_W-1:0]  rd_low_i,
    input  logic [1:0]                  rd_high_i,
    output logic [mcu_pkg::DATA_W-1:0]  dout_o,
    output logic                        dtack_n_o,
    output logic                        berr_n_o
);

    localparam int DIV_W  = (ENA_DIV > 1) ? $clog2(ENA_DIV) : 1;
    localparam int BERR_W = $clog2(BERR_TICKS + 1);
    localparam int PAD_W  = mcu_pkg::DATA_W - mcu_pkg::BYTE_W - 2;

    logic [DIV_W-1:0]         div_cnt;
    logic                     ena8;
    logic [SND_ACK_TICKS-1:0] snd_chain;
    logic [BERR_W-1:0]        berr_cnt;
    logic                     berr_hit;

    // 8 MHz enable from clk32
    always_ff @(posedge clk32, posedge isndcsb) begin
        if (isndcsb) begin
            div_cnt <= '0;
        end else if (ena8) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign ena8 = (div_cnt == DIV_W'(ENA_DIV - 1));

    // Sound select delayed by SND_ACK_TICKS enables
    always_ff @(posedge clk32, posedge isndcsb) begin
        if (isndcsb) begin
            snd_chain <= '0;
        end else if (!reg_i.snd_access) begin
            snd_chain <= '0;
        end else if (ena8) begin
            snd_chain <= (snd_chain << 1) | SND_ACK_TICKS'(1);
        end
    end

    // Timeout while AS stays low, holds at the limit
    always_ff @(posedge clk32, posedge isndcsb) begin
        if (isndcsb) begin
            berr_cnt <= '0;
        end else if (as_n_i) begin
            berr_cnt <= '0;
        end else if (ena8 && !berr_hit) begin
            berr_cnt <= berr_cnt + 1'b1;
        end
    end

    assign berr_hit = (berr_cnt == BERR_W'(BERR_TICKS));
    assign berr_n_o = ~berr_hit;

    // Released as soon as AS goes high
    assign dtack_n_o = ~(~as_n_i & (reg_i.ack | snd_chain[SND_ACK_TICKS-1]));

    assign dout_o = {{PAD_W{1'b1}}, rd_high_i, rd_low_i};  // D15-D10 float high

endmodule

//--- source/mcu_reg_file.sv
`timescale 1ns/1ps

module mcu_reg_file (
    input  logic                        clk32,
    input  logic                        isndcsb,
    mcu_reg_if.sink                     reg_i,
    output logic                        gamecart_o,
    output logic [mcu_pkg::BYTE_W-1:0]  rd_low_o,
    output logic [1:0]                  rd_high_o
);

    // Video base, A21-A1 of the screen start
    logic [5:0] vidb_h;
    logic [7:0] vidb_m;
    logic [7:1] vidb_l;
    logic [7:0] hoff;
    logic [3:0] conf_reg;
    logic [3:0] snd_ctrl;
    // Sound frame base, same layout as the video base
    logic [5:0] sfb_h;
    logic [7:0] sfb_m;
    logic [7:1] sfb_l;
    logic       gamecart;
    logic       pal;

    // Write strobe is a level, so the value is re-captured while it stays high
    always_ff @(posedge clk32, posedge isndcsb) begin
        if (isndcsb) begin
            vidb_h   <= '0;
            vidb_m   <= '0;
            vidb_l   <= '0;
            hoff     <= '0;
            conf_reg <= '0;
            snd_ctrl <= '0;
            sfb_h    <= '0;
            sfb_m    <= '0;
            sfb_l    <= '0;
            gamecart <= 1'b0;
            pal      <= 1'b0;
        end else if (reg_i.wr_strobe) begin
            case (reg_i.sel)
                mcu_pkg::VIDB_H:   vidb_h   <= reg_i.wdata[5:0];
                mcu_pkg::VIDB_M:   vidb_m   <= reg_i.wdata;
                mcu_pkg::VIDB_L:   vidb_l   <= reg_i.wdata[7:1];  // Word aligned
                mcu_pkg::HOFF:     hoff     <= reg_i.wdata;
                mcu_pkg::CONFIG:   conf_reg <= reg_i.wdata[3:0];
                mcu_pkg::SND_CTRL: snd_ctrl <= reg_i.wdata[3:0];
                mcu_pkg::SFB_H:    sfb_h    <= reg_i.wdata[5:0];
                mcu_pkg::SFB_M:    sfb_m    <= reg_i.wdata;
                mcu_pkg::SFB_L:    sfb_l    <= reg_i.wdata[7:1];
                mcu_pkg::CART:     gamecart <= reg_i.wdata[0];    // D8
                mcu_pkg::SYNC:     pal      <= reg_i.wdata[1];    // D9
                default: ;
            endcase
        end
    end

    always_comb begin
        rd_low_o  = mcu_pkg::IDLE_BYTE;
        rd_high_o = 2'b11;
        if (reg_i.rd_strobe) begin
            case (reg_i.sel)
                mcu_pkg::VIDB_H:   rd_low_o = {2'b00, vidb_h};
                mcu_pkg::VIDB_M:   rd_low_o = vidb_m;
                mcu_pkg::VIDB_L:   rd_low_o = {vidb_l, 1'b0};
                mcu_pkg::HOFF:     rd_low_o = hoff;
                mcu_pkg::CONFIG:   rd_low_o = {4'b0000, conf_reg};
                mcu_pkg::SND_CTRL: rd_low_o = {4'b0000, snd_ctrl};
                mcu_pkg::SFB_H:    rd_low_o = {2'b00, sfb_h};
                mcu_pkg::SFB_M:    rd_low_o = sfb_m;
                mcu_pkg::SFB_L:    rd_low_o = {sfb_l, 1'b0};
                mcu_pkg::CART:     rd_high_o = {1'b0, gamecart};
                mcu_pkg::SYNC:     rd_high_o = {pal, 1'b0};
                default: ;
            endcase
        end
    end

    assign gamecart_o = gamecart;  // Feeds the ROM 3/4 remap

endmodule

//--- source/mcu_addr_decode.sv
`timescale 1ns/1ps

module mcu_addr_decode (
    input  logic                            clk32,
    input  logic                            isndcsb,
    input  logic [2:0]                      fc_i,
    input  logic                            as_n_i,
    input  logic                            rw_i,
    input  logic                            uds_n_i,
    input  logic                            lds_n_i,
    input  logic [mcu_pkg::ADDR_W:1]        a_i,
    input  logic [mcu_pkg::DATA_W-1:0]      din_i,
    input  logic                            gamecart_i,
    output logic [mcu_pkg::ROM_BANKS-1:0]   rom_n_o,
    output logic                            mfpcs_n_o,
    mcu_reg_if.decoder                      reg_o
);

    logic                           as;
    logic                           uds;
    logic                           lds;
    logic                           dev;
    logic                           rom_rd;
    logic                           rvec;
    logic                           snd_hit;
    logic                           reg_hit;
    logic                           upper_lane;
    logic                           lane;
    logic [15:0]                    reg_adr;
    logic [mcu_pkg::ROM_BANKS-1:0]  rom_sel;
    mcu_pkg::reg_sel_e              sel_map;

    assign as  = ~as_n_i;
    assign uds = ~uds_n_i;
    assign lds = ~lds_n_i;

    // User or supervisor data space into the FF page
    assign dev     = as & (fc_i[1:0] == 2'b01) & (a_i[23:16] == mcu_pkg::DEV_PAGE);
    assign rom_rd  = as & rw_i & (fc_i[0] ^ fc_i[1]);  // Program or data, reads only
    assign rvec    = rom_rd & fc_i[2] & (a_i[23:3] == '0);  // Reset vectors 0-7
    assign reg_adr = {a_i[15:1], 1'b0};

    always_comb begin
        rom_sel[0] = rom_rd & (a_i[23:18] == 6'b111010);         // E8-EB
        rom_sel[1] = rom_rd & (a_i[23:18] == 6'b111001);         // E4-E7
        rom_sel[2] = rvec | (rom_rd & (a_i[23:18] == 6'b111000));
        // Cartridge moves banks 3 and 4 down into the D range
        rom_sel[3] = rom_rd & (gamecart_i ? (a_i[23:18] == 6'b110111)
                                          : (a_i[23:16] == 8'hFB));
        rom_sel[4] = rom_rd & (gamecart_i ? (a_i[23:18] == 6'b110110)
                                          : (a_i[23:16] == 8'hFA));
        rom_sel[5] = rom_rd & (a_i[23:18] == 6'b110101);         // D4-D7
        rom_sel[6] = rom_rd & (a_i[23:18] == 6'b110100);         // D0-D3
        rom_sel[7] = rom_rd & (a_i[23:13] == {8'hFE, 3'b000});   // ROMP
    end

    always_comb begin
        case (reg_adr)
            mcu_pkg::ADR_CONFIG:   sel_map = mcu_pkg::CONFIG;
            mcu_pkg::ADR_VIDB_H:   sel_map = mcu_pkg::VIDB_H;
            mcu_pkg::ADR_VIDB_M:   sel_map = mcu_pkg::VIDB_M;
            mcu_pkg::ADR_VIDB_L:   sel_map = mcu_pkg::VIDB_L;
            mcu_pkg::ADR_HOFF:     sel_map = mcu_pkg::HOFF;
            mcu_pkg::ADR_SYNC:     sel_map = mcu_pkg::SYNC;
            mcu_pkg::ADR_SND_CTRL: sel_map = mcu_pkg::SND_CTRL;
            mcu_pkg::ADR_SFB_H:    sel_map = mcu_pkg::SFB_H;
            mcu_pkg::ADR_SFB_M:    sel_map = mcu_pkg::SFB_M;
            mcu_pkg::ADR_SFB_L:    sel_map = mcu_pkg::SFB_L;
            mcu_pkg::ADR_CART:     sel_map = mcu_pkg::CART;
            default:               sel_map = mcu_pkg::REG_NONE;
        endcase
    end

    // Only the cartridge and sync flags sit on D15-D8
    assign upper_lane = (sel_map == mcu_pkg::CART) | (sel_map == mcu_pkg::SYNC);
    assign lane       = upper_lane ? uds : lds;
    assign reg_hit    = dev & (sel_map != mcu_pkg::REG_NONE);
    assign snd_hit    = dev & (a_i[15:5] == {mcu_pkg::SND_PAGE, 3'b000});

    assign reg_o.sel        = dev ? sel_map : mcu_pkg::REG_NONE;
    assign reg_o.wr_strobe  = reg_hit & ~rw_i & lane;
    assign reg_o.rd_strobe  = reg_hit & rw_i & lane;
    assign reg_o.wdata      = upper_lane ? din_i[mcu_pkg::DATA_W-1:mcu_pkg::BYTE_W]
                                         : din_i[mcu_pkg::BYTE_W-1:0];
    assign reg_o.snd_access = snd_hit;
    assign reg_o.ack        = (reg_hit & ~snd_hit) | (|rom_sel);  // Sound page waits

    assign rom_n_o   = ~rom_sel;
    assign mfpcs_n_o = ~(dev & (a_i[15:6] == {mcu_pkg::MFP_PAGE, 2'b00}));

endmodule

//--- source/mcu_reg_if.sv
`timescale 1ns/1ps

interface mcu_reg_if;

    mcu_pkg::reg_sel_e              sel;
    logic                           wr_strobe;   // Level, held with AS and byte strobe
    logic                           rd_strobe;
    logic [mcu_pkg::BYTE_W-1:0]     wdata;       // Already steered from the used lane
    logic                           snd_access;  // Any hit in the sound page
    logic                           ack;         // Immediate DTACK

    modport decoder (
        output sel, wr_strobe, rd_strobe, wdata, snd_access, ack
    );

    modport sink (
        input sel, wr_strobe, rd_strobe, wdata, snd_access, ack
    );

endinterface

//--- source/mcu_pkg.sv
package mcu_pkg;

    // Bus widths
    localparam int ADDR_W    = 23;              // A[23:1]
    localparam int DATA_W    = 16;
    localparam int BYTE_W    = 8;
    localparam int ROM_BANKS = 8;               // Bit 7 is ROMP

    localparam logic [7:0]        DEV_PAGE  = 8'hFF;
    localparam logic [BYTE_W-1:0] IDLE_BYTE = 8'hFF;

    // Device page windows, upper address bits of the low word
    localparam logic [7:0] MFP_PAGE = 8'hFA;    // FFFA0x-FFFA3x
    localparam logic [7:0] SND_PAGE = 8'h89;    // FF890x-FF891x

    // Even byte addresses within the device page
    localparam logic [15:0] ADR_CONFIG   = 16'h8000;
    localparam logic [15:0] ADR_VIDB_H   = 16'h8200;
    localparam logic [15:0] ADR_VIDB_M   = 16'h8202;
    localparam logic [15:0] ADR_SYNC     = 16'h820A;  // Upper lane
    localparam logic [15:0] ADR_VIDB_L   = 16'h820C;
    localparam logic [15:0] ADR_HOFF     = 16'h820E;
    localparam logic [15:0] ADR_SND_CTRL = 16'h8900;
    localparam logic [15:0] ADR_SFB_H    = 16'h8902;
    localparam logic [15:0] ADR_SFB_M    = 16'h8904;
    localparam logic [15:0] ADR_SFB_L    = 16'h8906;
    localparam logic [15:0] ADR_CART     = 16'h9000;  // Upper lane

    typedef enum logic [3:0] {
        REG_NONE,
        VIDB_H,
        VIDB_M,
        VIDB_L,
        HOFF,
        CONFIG,
        SND_CTRL,
        SFB_H,
        SFB_M,
        SFB_L,
        CART,
        SYNC
    } reg_sel_e;

endpackage
